/* Makefile */
VERILATOR ?= verilator
TOP       ?= exec_stage_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Checks failed" $(LOG); then \
		echo "simulation failed"; \
		exit 1; \
	fi
	@if ! grep -q "All checks passed" $(LOG); then \
		echo "simulation did not finish"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/exec_stage_sva.sv */
`timescale 1ns/1ns
`include "exec_defs.svh"

module exec_stage_sva (
    input logic              CLK,
    input logic              rst_n,
    input logic              flush,
    input logic              stall,
    input logic              hold,
    input exec_pkg::issue_t  cur,
    input logic              exec_valid,
    input exec_pkg::reg_wr_t reg_wr,
    input exec_pkg::mem_rd_t mem_rd,
    input exec_pkg::mem_wr_t mem_wr,
    input exec_pkg::jump_t   jump,
    input exec_pkg::exc_t    exc
);

    logic any_claim;

    assign any_claim = reg_wr.en | mem_rd.en | mem_wr.en | jump.taken | jump.not_taken;

    // reset loads a bubble, so only the x0 write may show
    reset_quiet: assert property (@(posedge CLK)
        !rst_n |=> !exec_valid && !mem_rd.en && !mem_wr.en && !jump.taken
                   && !jump.not_taken && !exc.en && reg_wr.rd == 5'd0)
        else $error("output active after a reset edge");

    flush_bubble: assert property (@(posedge CLK)
        flush |=> !cur.valid && cur.op == `EXEC_BUBBLE_OP)
        else $error("no bubble after flush");

    stall_bubble: assert property (@(posedge CLK)
        rst_n && stall && !hold && !flush |=> !cur.valid && cur.op == `EXEC_BUBBLE_OP)
        else $error("no bubble after stall");

    hold_keeps: assert property (@(posedge CLK)
        rst_n && hold && !flush |=> cur == $past(cur))
        else $error("cur changed across a held edge");

    exc_alone: assert property (@(posedge CLK)
        exc.en |-> !any_claim)
        else $error("exception raised together with a claim");

endmodule

/* verif/exec_stage_tb.sv */
`timescale 1ns/1ns
`include "exec_defs.svh"

module exec_stage_tb;

    logic                  CLK;
    logic                  rst_n;
    logic                  flush;
    logic                  stall;
    logic                  hold;
    exec_pkg::issue_t      issue_in;
    logic                  exec_valid;
    logic [`EXEC_XLEN-1:0] exec_pc;
    exec_pkg::reg_wr_t     reg_wr;
    exec_pkg::mem_rd_t     mem_rd;
    exec_pkg::mem_wr_t     mem_wr;
    exec_pkg::jump_t       jump;
    exec_pkg::exc_t        exc;

    int errors;
    int checks;
    int tests;
    int test_err0;

    exec_stage exec_stage_inst (.*);

    bind exec_stage exec_stage_sva sva_inst (
        .CLK(CLK), .rst_n(rst_n), .flush(flush), .stall(stall), .hold(hold),
        .cur(cur), .exec_valid(exec_valid), .reg_wr(reg_wr), .mem_rd(mem_rd),
        .mem_wr(mem_wr), .jump(jump), .exc(exc)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    function automatic logic [`EXEC_OP_W-1:0] mk_op(logic [6:0] o, logic [2:0] f3, logic [6:0] f7);
        return {o, f3, f7};
    endfunction

    function automatic exec_pkg::issue_t idle_issue();
        exec_pkg::issue_t i;
        i    = '0;
        i.op = `EXEC_BUBBLE_OP;
        return i;
    endfunction

    function automatic exec_pkg::issue_t rand_issue(logic [`EXEC_OP_W-1:0] op);
        exec_pkg::issue_t i;
        i.valid    = 1'b1;
        i.pc       = $urandom & 32'hffff_fffc;
        i.op       = op;
        i.rd       = 5'($urandom);
        i.rs1_data = $urandom;
        i.rs2_data = $urandom;
        i.imm      = $urandom;
        return i;
    endfunction

    // reference model built from the stage's instruction rules
    task automatic model(input exec_pkg::issue_t i, output exec_pkg::reg_wr_t r,
                         output exec_pkg::mem_rd_t mr, output exec_pkg::mem_wr_t mw,
                         output exec_pkg::jump_t j, output exec_pkg::exc_t e);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] ii;
        logic [31:0] v;
        logic        ok;
        logic        c;
        opc = i.op[16:10];
        f3  = i.op[9:7];
        f7  = i.op[6:0];
        a   = i.rs1_data;
        ii  = {{20{i.imm[11]}}, i.imm[11:0]};
        b   = (opc == `EXEC_OPC_OP) ? i.rs2_data : ii;
        r   = '0;
        mr  = '0;
        mw  = '0;
        j   = '0;
        e   = '0;
        ok = 1'b0;
        v  = 32'd0;
        case (f3)
            3'd0: v = (opc == `EXEC_OPC_OP && f7 == `EXEC_F7_ALT) ? a - b : a + b;
            3'd1: v = a << b[4:0];
            3'd2: v = {31'd0, $signed(a) < $signed(b)};
            3'd3: v = {31'd0, a < b};
            3'd4: v = a ^ b;
            3'd5: v = (f7 == `EXEC_F7_ALT) ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: v = a | b;
            default: v = a & b;
        endcase
        if (opc == `EXEC_OPC_OP) begin
            ok = (f7 == 7'd0) || (f7 == `EXEC_F7_ALT && (f3 == 3'd0 || f3 == 3'd5));
        end else if (opc == `EXEC_OPC_OPIMM) begin
            ok = (f3 == 3'd1) ? (f7 == 7'd0) :
                 (f3 == 3'd5) ? (f7 == 7'd0 || f7 == `EXEC_F7_ALT) : 1'b1;
        end else if (opc == `EXEC_OPC_LUI) begin
            ok = 1'b1;
            v  = {i.imm[31:12], 12'd0};
        end else if (opc == `EXEC_OPC_AUIPC) begin
            ok = 1'b1;
            v  = i.pc + {i.imm[31:12], 12'd0};
        end else if (opc == `EXEC_OPC_JAL || (opc == `EXEC_OPC_JALR && f3 == 3'd0)) begin
            ok = 1'b1;
            v  = i.pc + 32'd4;
        end
        if (ok) begin
            r.en   = 1'b1;
            r.rd   = i.rd;
            r.data = v;
        end
        if (opc == `EXEC_OPC_BRANCH && f3 != 3'd2 && f3 != 3'd3) begin
            case (f3)
                3'd0: c = (a == i.rs2_data);
                3'd1: c = (a != i.rs2_data);
                3'd4: c = $signed(a) < $signed(i.rs2_data);
                3'd5: c = $signed(a) >= $signed(i.rs2_data);
                3'd6: c = a < i.rs2_data;
                default: c = a >= i.rs2_data;
            endcase
            j.taken     = c;
            j.not_taken = !c;
            j.target = i.pc + {{19{i.imm[12]}}, i.imm[12:1], 1'b0};
        end else if (opc == `EXEC_OPC_JAL) begin
            j.taken = 1'b1;
            j.target = i.pc + {{11{i.imm[20]}}, i.imm[20:1], 1'b0};
        end else if (opc == `EXEC_OPC_JALR && f3 == 3'd0) begin
            j.taken = 1'b1;
            j.target = (a + ii) & 32'hffff_fffe;   // bit 0 cleared
        end
        if (opc == `EXEC_OPC_LOAD && (f3 <= 3'd2 || f3 == 3'd4 || f3 == 3'd5)) begin
            mr.en   = 1'b1;
            mr.rd   = i.rd;
            mr.addr = a + ii;
            mr.strb = (f3[1:0] == 2'd0) ? 4'b0001 : (f3[1:0] == 2'd1) ? 4'b0011 : 4'b1111;
            mr.is_signed = (f3 == 3'd0 || f3 == 3'd1);
        end
        if (opc == `EXEC_OPC_STORE && f3 <= 3'd2) begin
            mw.en   = 1'b1;
            mw.addr = a + ii;
            mw.data = i.rs2_data;
            mw.strb = (f3 == 3'd0) ? 4'b0001 : (f3 == 3'd1) ? 4'b0011 : 4'b1111;
        end
        if (i.op == mk_op(`EXEC_OPC_SYSTEM, 3'd0, 7'd0)) begin
            e.en   = 1'b1;
            e.code = (i.imm[11:0] != 12'd0) ? 4'd3 : 4'd11;
        end else if (!(r.en || mr.en || mw.en || j.taken || j.not_taken)) begin
            e.en   = 1'b1;
            e.code = 4'd2;
        end
    endtask

    task automatic check(input logic cond, input string msg);
        checks++;
        assert (cond) else begin
            $display("FAILED at %0t: %s", $time, msg);
            errors++;
        end
    endtask

    task automatic check_outputs(input exec_pkg::issue_t i);
        exec_pkg::reg_wr_t r;
        exec_pkg::mem_rd_t mr;
        exec_pkg::mem_wr_t mw;
        exec_pkg::jump_t   j;
        exec_pkg::exc_t    e;
        model(i, r, mr, mw, j, e);
        check(exec_valid && exec_pc == i.pc, $sformatf("valid/pc for op %h", i.op));
        check(reg_wr == r, $sformatf("reg_wr %h expected %h op %h", reg_wr, r, i.op));
        check(mem_rd == mr, $sformatf("mem_rd %h expected %h op %h", mem_rd, mr, i.op));
        check(mem_wr == mw, $sformatf("mem_wr %h expected %h op %h", mem_wr, mw, i.op));
        check(jump == j, $sformatf("jump %h expected %h op %h", jump, j, i.op));
        check(exc == e, $sformatf("exc %h expected %h op %h", exc, e, i.op));
    endtask

    task automatic check_bubble(input string where);
        check(!exec_valid && !mem_rd.en && !mem_wr.en && !jump.taken && !jump.not_taken
              && !exc.en && reg_wr.rd == 5'd0, {"bubble expected ", where});
    endtask

    task automatic timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("Checks failed");
        $finish;
    endtask

    // issue one instruction and wait for it on the outputs
    task automatic run_one(input exec_pkg::issue_t i);
        int n;
        @(posedge CLK);
        issue_in <= i;
        for (n = 0; n < 8; n++) begin
            @(posedge CLK);
            issue_in <= idle_issue();
            @(negedge CLK);
            if (exec_valid) break;
        end
        if (n == 8) begin
            timeout("exec_valid after issue");
        end else begin
            check_outputs(i);
        end
    endtask

    task automatic begin_test();
        tests++;
        test_err0 = errors;
    endtask

    task automatic end_test(input string name);
        $display("test %0d %s: %0d errors", tests, name, errors - test_err0);
    endtask

    initial begin
        exec_pkg::issue_t i;
        logic [6:0]       o;
        int               k;
        int               n;
        void'($urandom(32'haeeb));
        errors   = 0;
        checks   = 0;
        tests    = 0;
        rst_n    = 1'b0;
        flush    = 1'b0;
        stall    = 1'b0;
        hold     = 1'b0;
        issue_in = idle_issue();

        begin_test();
        for (n = 0; n < 3; n++) begin
            @(posedge CLK);
            if (n == 2) rst_n <= 1'b1;
            @(negedge CLK);
            check_bubble("in reset");
        end
        @(posedge CLK);
        @(negedge CLK);
        check_bubble("after reset");
        end_test("reset");

        begin_test();
        for (k = 0; k < 12; k++) begin
            for (n = 0; n < 8; n++) begin
                run_one(rand_issue(mk_op(`EXEC_OPC_OP, 3'(n), 7'd0)));
                run_one(rand_issue(mk_op(`EXEC_OPC_OPIMM, 3'(n), 7'd0)));
            end
            run_one(rand_issue(mk_op(`EXEC_OPC_OP, 3'd0, `EXEC_F7_ALT)));
            run_one(rand_issue(mk_op(`EXEC_OPC_OP, 3'd5, `EXEC_F7_ALT)));
            run_one(rand_issue(mk_op(`EXEC_OPC_OPIMM, 3'd5, `EXEC_F7_ALT)));
            run_one(rand_issue(mk_op(`EXEC_OPC_LUI, 3'(k), 7'd0)));
            run_one(rand_issue(mk_op(`EXEC_OPC_AUIPC, 3'(k), 7'd0)));
        end
        end_test("integer");

        begin_test();
        for (k = 0; k < 12; k++) begin
            for (n = 0; n < 8; n++) begin
                i = rand_issue(mk_op(`EXEC_OPC_BRANCH, 3'(n), 7'd0));
                if (k % 3 == 0) i.rs2_data = i.rs1_data;
                if (k % 3 == 1) i.rs2_data = i.rs1_data ^ 32'h8000_0000;
                run_one(i);
            end
            run_one(rand_issue(mk_op(`EXEC_OPC_JAL, 3'(k), 7'd0)));
            run_one(rand_issue(mk_op(`EXEC_OPC_JALR, 3'd0, 7'd0)));
        end
        end_test("branch");

        begin_test();
        for (k = 0; k < 10; k++) begin
            for (n = 0; n < 8; n++) begin
                run_one(rand_issue(mk_op(`EXEC_OPC_LOAD, 3'(n), 7'd0)));
                run_one(rand_issue(mk_op(`EXEC_OPC_STORE, 3'(n), 7'd0)));
            end
        end
        end_test("memory");

        begin_test();
        i = rand_issue(mk_op(`EXEC_OPC_SYSTEM, 3'd0, 7'd0));
        i.imm = 32'd0;
        run_one(i);                                           // ecall
        i.imm = 32'd1;
        run_one(i);                                           // ebreak
        run_one(rand_issue(mk_op(`EXEC_OPC_SYSTEM, 3'd1, 7'd0)));        // csrrw
        run_one(rand_issue(mk_op(`EXEC_OPC_SYSTEM, 3'd6, 7'd0)));        // csrrsi
        run_one(rand_issue(mk_op(`EXEC_OPC_SYSTEM, 3'd0, 7'b0011000)));  // mret
        run_one(rand_issue(mk_op(7'b0001111, 3'd0, 7'd0)));              // fence
        run_one(rand_issue(mk_op(7'b0001111, 3'd1, 7'd0)));              // fence.i
        for (k = 0; k < 20; k++) begin
            o = 7'($urandom);
            if (o != `EXEC_OPC_OP && o != `EXEC_OPC_OPIMM && o != `EXEC_OPC_LUI &&
                o != `EXEC_OPC_AUIPC && o != `EXEC_OPC_JAL && o != `EXEC_OPC_JALR &&
                o != `EXEC_OPC_BRANCH && o != `EXEC_OPC_LOAD && o != `EXEC_OPC_STORE &&
                o != `EXEC_OPC_SYSTEM) begin
                run_one(rand_issue(mk_op(o, 3'($urandom), 7'($urandom))));
            end
        end
        end_test("exception");

        begin_test();
        @(posedge CLK);
        issue_in <= rand_issue(mk_op(`EXEC_OPC_LOAD, 3'd2, 7'd0));
        stall    <= 1'b1;
        @(posedge CLK);
        stall    <= 1'b0;
        issue_in <= rand_issue(mk_op(`EXEC_OPC_STORE, 3'd2, 7'd0));
        flush    <= 1'b1;
        @(negedge CLK);
        check_bubble("after stall");
        @(posedge CLK);
        flush    <= 1'b0;
        issue_in <= idle_issue();
        @(negedge CLK);
        check_bubble("after flush");
        i = rand_issue(mk_op(`EXEC_OPC_OP, 3'd5, `EXEC_F7_ALT));
        @(posedge CLK);
        issue_in <= i;
        @(posedge CLK);
        issue_in <= rand_issue(mk_op(`EXEC_OPC_JAL, 3'd0, 7'd0));
        hold     <= 1'b1;
        @(negedge CLK);
        check_outputs(i);
        for (n = 0; n < 2; n++) begin
            @(posedge CLK);
            if (n == 1) begin
                hold     <= 1'b0;
                issue_in <= idle_issue();
            end
            @(negedge CLK);
            check_outputs(i);                                 // held
        end
        @(posedge CLK);
        @(negedge CLK);
        check_bubble("after hold release");
        run_one(rand_issue(mk_op(`EXEC_OPC_OP, 3'd0, 7'd0)));
        @(posedge CLK);
        issue_in <= rand_issue(mk_op(`EXEC_OPC_OP, 3'd4, 7'd0));
        @(posedge CLK);
        issue_in <= idle_issue();
        hold     <= 1'b1;
        flush    <= 1'b1;
        @(posedge CLK);
        hold     <= 1'b0;
        flush    <= 1'b0;
        @(negedge CLK);
        check_bubble("flush over hold");
        end_test("control");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+verilog
verilog/exec_pkg.sv
verilog/exec_issue_latch.sv
verilog/exec_alu.sv
verilog/exec_branch_unit.sv
verilog/exec_lsu_agu.sv
verilog/exec_trap_check.sv
verilog/exec_stage.sv
verif/exec_stage_sva.sv
verif/exec_stage_tb.sv

/* verilog/exec_alu.sv */
`timescale 1ns/1ns
`include "exec_defs.svh"

module exec_alu (
    input  exec_pkg::issue_t  cur,
    output exec_pkg::reg_wr_t reg_wr
);

    logic [6:0]            opc;
    logic [2:0]            f3;
    logic [6:0]            f7;
    logic [`EXEC_XLEN-1:0] imm_i;
    logic [`EXEC_XLEN-1:0] opb;
    logic [`EXEC_XLEN-1:0] sra_res;
    logic [`EXEC_XLEN-1:0] arith;
    logic [`EXEC_XLEN-1:0] res;
    logic [`EXEC_XLEN-1:0] upper;
    logic [4:0]            shamt;
    logic                  alt;
    logic                  legal;
    logic                  hit;

    assign opc     = cur.op[16:10];
    assign f3      = cur.op[9:7];
    assign f7      = cur.op[6:0];
    assign imm_i   = {{(`EXEC_XLEN-12){cur.imm[11]}}, cur.imm[11:0]};
    assign opb     = (opc == `EXEC_OPC_OP) ? cur.rs2_data : imm_i;
    assign shamt   = opb[4:0];            // low 5 bits only
    assign alt     = (f7 == `EXEC_F7_ALT);
    assign sra_res = $signed(cur.rs1_data) >>> shamt;
    assign upper   = {cur.imm[31:12], 12'b0};

    // funct7 must match for reg-reg ops and immediate shifts
    always_comb begin
        if (opc == `EXEC_OPC_OP) begin
            legal = (f7 == `EXEC_F7_ZERO) || (alt && (f3 == `EXEC_F3_ADD || f3 == `EXEC_F3_SR));
        end else if (f3 == `EXEC_F3_SLL) begin
            legal = (f7 == `EXEC_F7_ZERO);
        end else if (f3 == `EXEC_F3_SR) begin
            legal = (f7 == `EXEC_F7_ZERO) || alt;
        end else begin
            legal = 1'b1;
        end
    end

    always_comb begin
        case (f3)
            `EXEC_F3_ADD: begin
                if (alt && opc == `EXEC_OPC_OP) begin
                    arith = cur.rs1_data - opb;
                end else begin
                    arith = cur.rs1_data + opb;
                end
            end
            `EXEC_F3_SLL:  arith = cur.rs1_data << shamt;
            `EXEC_F3_SLT:  arith = {{(`EXEC_XLEN-1){1'b0}}, $signed(cur.rs1_data) < $signed(opb)};
            `EXEC_F3_SLTU: arith = {{(`EXEC_XLEN-1){1'b0}}, cur.rs1_data < opb};
            `EXEC_F3_XOR:  arith = cur.rs1_data ^ opb;
            `EXEC_F3_SR:   arith = alt ? sra_res : cur.rs1_data >> shamt;
            `EXEC_F3_OR:   arith = cur.rs1_data | opb;
            default:       arith = cur.rs1_data & opb;
        endcase
    end

    always_comb begin
        hit = 1'b1;
        res = '0;
        case (opc)
            `EXEC_OPC_OP, `EXEC_OPC_OPIMM: begin
                hit = legal;
                res = arith;                  // bubble lands here as a write to x0
            end
            `EXEC_OPC_LUI:   res = upper;
            `EXEC_OPC_AUIPC: res = cur.pc + upper;
            `EXEC_OPC_JAL:   res = cur.pc + 32'd4;
            `EXEC_OPC_JALR: begin
                hit = (f3 == `EXEC_F3_JALR);
                res = cur.pc + 32'd4;         // link value
            end
            default:         hit = 1'b0;
        endcase
    end

    assign reg_wr.en   = hit;
    assign reg_wr.rd   = hit ? cur.rd : '0;
    assign reg_wr.data = hit ? res : '0;

endmodule

/* verilog/exec_branch_unit.sv */
`timescale 1ns/1ns
`include "exec_defs.svh"

module exec_branch_unit (
    input  exec_pkg::issue_t cur,
    output exec_pkg::jump_t  jump
);

    logic [6:0]            opc;
    logic [2:0]            f3;
    logic [`EXEC_XLEN-1:0] br_off;
    logic [`EXEC_XLEN-1:0] jal_off;
    logic [`EXEC_XLEN-1:0] jalr_sum;
    logic                  eq;
    logic                  lt;
    logic                  ltu;
    logic                  br_known;
    logic                  br_cond;

    assign opc      = cur.op[16:10];
    assign f3       = cur.op[9:7];
    assign br_off   = {{(`EXEC_XLEN-13){cur.imm[12]}}, cur.imm[12:1], 1'b0};
    assign jal_off  = {{(`EXEC_XLEN-21){cur.imm[20]}}, cur.imm[20:1], 1'b0};
    assign jalr_sum = cur.rs1_data + {{(`EXEC_XLEN-12){cur.imm[11]}}, cur.imm[11:0]};
    assign eq       = (cur.rs1_data == cur.rs2_data);
    assign lt       = ($signed(cur.rs1_data) < $signed(cur.rs2_data));
    assign ltu      = (cur.rs1_data < cur.rs2_data);

    always_comb begin
        br_known = 1'b1;
        case (f3)
            `EXEC_F3_BEQ:  br_cond = eq;
            `EXEC_F3_BNE:  br_cond = !eq;
            `EXEC_F3_BLT:  br_cond = lt;
            `EXEC_F3_BGE:  br_cond = !lt;
            `EXEC_F3_BLTU: br_cond = ltu;
            `EXEC_F3_BGEU: br_cond = !ltu;
            default: begin
                br_known = 1'b0;     // funct3 010/011 unused
                br_cond  = 1'b0;
            end
        endcase
    end

    always_comb begin
        jump = '0;
        if (opc == `EXEC_OPC_BRANCH && br_known) begin
            jump.taken     = br_cond;
            jump.not_taken = !br_cond;
            jump.target    = cur.pc + br_off;
        end else if (opc == `EXEC_OPC_JAL) begin
            jump.taken  = 1'b1;
            jump.target = cur.pc + jal_off;
        end else if (opc == `EXEC_OPC_JALR && f3 == `EXEC_F3_JALR) begin
            jump.taken  = 1'b1;
            jump.target = {jalr_sum[`EXEC_XLEN-1:1], 1'b0};
        end
    end

endmodule

/* verilog/exec_defs.svh */
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

`define EXEC_XLEN        32
`define EXEC_REG_AW      5
`define EXEC_OP_W        17             // {opcode, funct3, funct7}
`define EXEC_STRB_W      4
`define EXEC_EXC_W       4

// major opcodes
`define EXEC_OPC_OP      7'b0110011
`define EXEC_OPC_OPIMM   7'b0010011
`define EXEC_OPC_LUI     7'b0110111
`define EXEC_OPC_AUIPC   7'b0010111
`define EXEC_OPC_JAL     7'b1101111
`define EXEC_OPC_JALR    7'b1100111
`define EXEC_OPC_BRANCH  7'b1100011
`define EXEC_OPC_LOAD    7'b0000011
`define EXEC_OPC_STORE   7'b0100011
`define EXEC_OPC_SYSTEM  7'b1110011

`define EXEC_F7_ZERO     7'b0000000
`define EXEC_F7_ALT      7'b0100000     // sub, sra, srai

// funct3 of integer ops
`define EXEC_F3_ADD      3'b000
`define EXEC_F3_SLL      3'b001
`define EXEC_F3_SLT      3'b010
`define EXEC_F3_SLTU     3'b011
`define EXEC_F3_XOR      3'b100
`define EXEC_F3_SR       3'b101
`define EXEC_F3_OR       3'b110
`define EXEC_F3_AND      3'b111
`define EXEC_F3_JALR     3'b000

// funct3 of branches
`define EXEC_F3_BEQ      3'b000
`define EXEC_F3_BNE      3'b001
`define EXEC_F3_BLT      3'b100
`define EXEC_F3_BGE      3'b101
`define EXEC_F3_BLTU     3'b110
`define EXEC_F3_BGEU     3'b111

// funct3 of loads and stores
`define EXEC_F3_B        3'b000
`define EXEC_F3_H        3'b001
`define EXEC_F3_W        3'b010
`define EXEC_F3_BU       3'b100
`define EXEC_F3_HU       3'b101

`define EXEC_STRB_BYTE   4'b0001
`define EXEC_STRB_HALF   4'b0011
`define EXEC_STRB_WORD   4'b1111

`define EXEC_BUBBLE_OP   {`EXEC_OPC_OPIMM, `EXEC_F3_ADD, `EXEC_F7_ZERO}

`define EXEC_EXC_ILLEGAL 4'd2
`define EXEC_EXC_BREAK   4'd3
`define EXEC_EXC_ECALL   4'd11

`endif

/* verilog/exec_issue_latch.sv */
`timescale 1ns/1ns
`include "exec_defs.svh"

module exec_issue_latch (
    input  logic             CLK,
    input  logic             rst_n,
    input  logic             flush,
    input  logic             stall,
    input  logic             hold,
    input  exec_pkg::issue_t issue_in,
    output exec_pkg::issue_t cur
);

    exec_pkg::issue_t bubble;

    // addi x0, x0, 0 with valid low
    always_comb begin
        bubble    = '0;
        bubble.op = `EXEC_BUBBLE_OP;
    end

    always_ff @(posedge CLK) begin
        if (!rst_n || flush) begin
            cur <= bubble;
        end else if (hold) begin
            cur <= cur;         // mmu wait
        end else if (stall) begin
            cur <= bubble;
        end else begin
            cur <= issue_in;
        end
    end

endmodule

/* verilog/exec_lsu_agu.sv */
`timescale 1ns/1ns
`include "exec_defs.svh"

module exec_lsu_agu (
    input  exec_pkg::issue_t  cur,
    output exec_pkg::mem_rd_t mem_rd,
    output exec_pkg::mem_wr_t mem_wr
);

    logic [6:0]            opc;
    logic [2:0]            f3;
    logic [`EXEC_XLEN-1:0] addr;

    assign opc  = cur.op[16:10];
    assign f3   = cur.op[9:7];
    assign addr = cur.rs1_data + {{(`EXEC_XLEN-12){cur.imm[11]}}, cur.imm[11:0]};

    // loads
    always_comb begin
        mem_rd = '0;
        if (opc == `EXEC_OPC_LOAD) begin
            mem_rd.en   = 1'b1;
            mem_rd.rd   = cur.rd;
            mem_rd.addr = addr;
            case (f3)
                `EXEC_F3_B: begin
                    mem_rd.strb      = `EXEC_STRB_BYTE;
                    mem_rd.is_signed = 1'b1;
                end
                `EXEC_F3_BU: mem_rd.strb = `EXEC_STRB_BYTE;
                `EXEC_F3_H: begin
                    mem_rd.strb      = `EXEC_STRB_HALF;
                    mem_rd.is_signed = 1'b1;
                end
                `EXEC_F3_HU: mem_rd.strb = `EXEC_STRB_HALF;
                `EXEC_F3_W:  mem_rd.strb = `EXEC_STRB_WORD;   // no sign on a full word
                default:     mem_rd      = '0;
            endcase
        end
    end

    // stores
    always_comb begin
        mem_wr = '0;
        if (opc == `EXEC_OPC_STORE) begin
            mem_wr.en   = 1'b1;
            mem_wr.addr = addr;
            mem_wr.data = cur.rs2_data;
            case (f3)
                `EXEC_F3_B: mem_wr.strb = `EXEC_STRB_BYTE;
                `EXEC_F3_H: mem_wr.strb = `EXEC_STRB_HALF;
                `EXEC_F3_W: mem_wr.strb = `EXEC_STRB_WORD;
                default:    mem_wr      = '0;
            endcase
        end
    end

endmodule

/* verilog/exec_pkg.sv */
`include "exec_defs.svh"

package exec_pkg;

    // one issued instruction from decode
    typedef struct packed {
        logic                    valid;
        logic [`EXEC_XLEN-1:0]   pc;
        logic [`EXEC_OP_W-1:0]   op;        // opcode, funct3, funct7
        logic [`EXEC_REG_AW-1:0] rd;
        logic [`EXEC_XLEN-1:0]   rs1_data;
        logic [`EXEC_XLEN-1:0]   rs2_data;
        logic [`EXEC_XLEN-1:0]   imm;
    } issue_t;

    typedef struct packed {
        logic                    en;
        logic [`EXEC_REG_AW-1:0] rd;
        logic [`EXEC_XLEN-1:0]   data;
    } reg_wr_t;

    typedef struct packed {
        logic                     en;
        logic [`EXEC_REG_AW-1:0]  rd;
        logic [`EXEC_XLEN-1:0]    addr;
        logic [`EXEC_STRB_W-1:0]  strb;
        logic                     is_signed;   // sign extend on return
    } mem_rd_t;

    typedef struct packed {
        logic                     en;
        logic [`EXEC_XLEN-1:0]    addr;
        logic [`EXEC_STRB_W-1:0]  strb;
        logic [`EXEC_XLEN-1:0]    data;
    } mem_wr_t;

    typedef struct packed {
        logic                    taken;
        logic                    not_taken;
        logic [`EXEC_XLEN-1:0]   target;
    } jump_t;

    typedef struct packed {
        logic                    en;
        logic [`EXEC_EXC_W-1:0]  code;
    } exc_t;

endpackage

/* verilog/exec_stage.sv */
`timescale 1ns/1ns
`include "exec_defs.svh"

module exec_stage (
    input  logic                  CLK,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  stall,
    input  logic                  hold,
    input  exec_pkg::issue_t      issue_in,
    output logic                  exec_valid,
    output logic [`EXEC_XLEN-1:0] exec_pc,
    output exec_pkg::reg_wr_t     reg_wr,
    output exec_pkg::mem_rd_t     mem_rd,
    output exec_pkg::mem_wr_t     mem_wr,
    output exec_pkg::jump_t       jump,
    output exec_pkg::exc_t        exc
);

    exec_pkg::issue_t cur;
    logic             claimed;

    exec_issue_latch latch_inst (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .flush    (flush),
        .stall    (stall),
        .hold     (hold),
        .issue_in (issue_in),
        .cur      (cur)
    );

    exec_alu alu_inst (.cur(cur), .reg_wr(reg_wr));

    exec_branch_unit branch_inst (.cur(cur), .jump(jump));

    exec_lsu_agu lsu_inst (.cur(cur), .mem_rd(mem_rd), .mem_wr(mem_wr));

    // any unit that recognised the code
    assign claimed = reg_wr.en | mem_rd.en | mem_wr.en | jump.taken | jump.not_taken;

    exec_trap_check trap_inst (.op(cur.op), .imm(cur.imm), .claimed(claimed), .exc(exc));

    assign exec_valid = cur.valid;
    assign exec_pc    = cur.pc;

endmodule

/* verilog/exec_trap_check.sv */
`timescale 1ns/1ns
`include "exec_defs.svh"

module exec_trap_check (
    input  logic [`EXEC_OP_W-1:0] op,
    input  logic [`EXEC_XLEN-1:0] imm,
    input  logic                  claimed,
    output exec_pkg::exc_t        exc
);

    // ecall and ebreak share the one exact system code
    localparam logic [`EXEC_OP_W-1:0] env_op = {`EXEC_OPC_SYSTEM, 3'b000, `EXEC_F7_ZERO};

    always_comb begin
        if (op == env_op) begin
            exc.en   = 1'b1;
            exc.code = (imm[11:0] != 12'b0) ? `EXEC_EXC_BREAK : `EXEC_EXC_ECALL;
        end else if (!claimed) begin
            exc.en   = 1'b1;                 // no unit took it
            exc.code = `EXEC_EXC_ILLEGAL;
        end else begin
            exc.en   = 1'b0;
            exc.code = '0;
        end
    end

endmodule
